// ==== design/evict_fill_pkg.sv ====
`default_nettype none

package evict_fill_pkg;

  // data word and DMA beat widths
  localparam int word_width_c = 32;
  localparam int dma_width_c = 64;

  // one cache block, split evenly across the even and odd banks
  localparam int block_words_c = 8;

  // default cache geometry, overridden from the top level
  localparam int default_ways_c = 4;
  localparam int default_sets_c = 16;

  // byte enables per DMA beat
  localparam int mask_width_c = dma_width_c / 8;

  // each bank holds half the block words, packed into DMA beats
  localparam int bursts_per_bank_c = (block_words_c / 2) * word_width_c / dma_width_c;

  // transfer mode held by the control block for the whole transfer
  typedef enum logic [1:0] {
    mode_idle   = 2'b00,
    mode_evict  = 2'b01,
    mode_refill = 2'b10
  } mode_e;

endpackage

`default_nettype wire

// ==== design/beat_fifo.sv ====
`default_nettype none

module beat_fifo #(
  parameter int els_p = 2,
  localparam int ptr_width_lp = (els_p > 1) ? $clog2(els_p) : 1,
  localparam int cnt_width_lp = $clog2(els_p + 1)
) (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   v_i,
  input  logic [evict_fill_pkg::dma_width_c-1:0] data_i,
  output logic                                   ready_o,
  output logic                                   v_o,
  output logic [evict_fill_pkg::dma_width_c-1:0] data_o,
  input  logic                                   yumi_i
);

  logic [evict_fill_pkg::dma_width_c-1:0] mem_r [els_p];
  logic [ptr_width_lp-1:0] wr_ptr_r;
  logic [ptr_width_lp-1:0] rd_ptr_r;
  logic [cnt_width_lp-1:0] count_r;
  logic push;
  logic pop;

  assign ready_o = (count_r != cnt_width_lp'(els_p));
  assign v_o = (count_r != '0);
  assign push = v_i & ready_o;
  // yumi is only raised against a valid head entry
  assign pop = yumi_i;
  assign data_o = mem_r[rd_ptr_r];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r <= '0;
    end else begin
      if (push) begin
        if (wr_ptr_r == ptr_width_lp'(els_p - 1)) begin
          wr_ptr_r <= '0;
        end else begin
          wr_ptr_r <= wr_ptr_r + 1'b1;
        end
      end
      if (pop) begin
        if (rd_ptr_r == ptr_width_lp'(els_p - 1)) begin
          rd_ptr_r <= '0;
        end else begin
          rd_ptr_r <= rd_ptr_r + 1'b1;
        end
      end
      // simultaneous push and pop leave the occupancy unchanged
      if (push && !pop) begin
        count_r <= count_r + 1'b1;
      end else if (pop && !push) begin
        count_r <= count_r - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/transfer_control.sv ====
`default_nettype none

module transfer_control #(
  parameter int ways_p = evict_fill_pkg::default_ways_c,
  parameter int sets_p = evict_fill_pkg::default_sets_c,
  parameter int bursts_p = evict_fill_pkg::bursts_per_bank_c,
  localparam int lg_ways_lp = (ways_p > 1) ? $clog2(ways_p) : 1,
  localparam int lg_sets_lp = (sets_p > 1) ? $clog2(sets_p) : 1,
  localparam int take_width_lp = $clog2(bursts_p + 1)
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  cmd_v_i,
  input  logic                  cmd_evict_i,
  input  logic [lg_ways_lp-1:0] cmd_way_i,
  input  logic [lg_sets_lp-1:0] cmd_set_i,
  output logic                  cmd_ready_o,
  input  logic                  even_done_i,
  input  logic                  odd_done_i,
  input  logic                  drain_empty_i,
  input  logic                  refill_take_i,
  output logic                  refill_open_o,
  output evict_fill_pkg::mode_e mode_o,
  output logic [lg_ways_lp-1:0] way_o,
  output logic [lg_sets_lp-1:0] set_o,
  output logic                  evict_done_o,
  output logic                  refill_done_o
);

  evict_fill_pkg::mode_e mode_r;
  logic [lg_ways_lp-1:0] way_r;
  logic [lg_sets_lp-1:0] set_r;
  logic [take_width_lp-1:0] take_count_r;
  logic cmd_accept;
  logic banks_done;

  assign cmd_ready_o = (mode_r == evict_fill_pkg::mode_idle);
  assign cmd_accept = cmd_v_i & cmd_ready_o;
  assign banks_done = even_done_i & odd_done_i;

  // an evict is only finished once every beat has left toward DMA
  assign evict_done_o = (mode_r == evict_fill_pkg::mode_evict) & banks_done & drain_empty_i;
  assign refill_done_o = (mode_r == evict_fill_pkg::mode_refill) & banks_done;

  // DMA may hand over at most one block worth of beat pairs per refill
  assign refill_open_o = (take_count_r < take_width_lp'(bursts_p));

  assign mode_o = mode_r;
  assign way_o = way_r;
  assign set_o = set_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mode_r <= evict_fill_pkg::mode_idle;
      way_r <= '0;
      set_r <= '0;
    end else begin
      if (cmd_accept) begin
        if (cmd_evict_i) begin
          mode_r <= evict_fill_pkg::mode_evict;
        end else begin
          mode_r <= evict_fill_pkg::mode_refill;
        end
        way_r <= cmd_way_i;
        set_r <= cmd_set_i;
      end else if (evict_done_o || refill_done_o) begin
        mode_r <= evict_fill_pkg::mode_idle;
      end
    end
  end

  // pair counter restarts whenever the mover is idle
  always_ff @(posedge clk_i) begin
    if (reset_i || (mode_r == evict_fill_pkg::mode_idle)) begin
      take_count_r <= '0;
    end else if (refill_take_i) begin
      take_count_r <= take_count_r + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== design/bank_port.sv ====
`default_nettype none

module bank_port #(
  parameter int ways_p = evict_fill_pkg::default_ways_c,
  parameter int sets_p = evict_fill_pkg::default_sets_c,
  parameter int bursts_p = evict_fill_pkg::bursts_per_bank_c,
  localparam int lg_ways_lp = (ways_p > 1) ? $clog2(ways_p) : 1,
  localparam int lg_sets_lp = (sets_p > 1) ? $clog2(sets_p) : 1,
  localparam int lg_bursts_lp = (bursts_p > 1) ? $clog2(bursts_p) : 1,
  localparam int cnt_width_lp = $clog2(bursts_p + 2),
  localparam int mask_width_lp = evict_fill_pkg::mask_width_c
) (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  evict_fill_pkg::mode_e                  mode_i,
  input  logic [lg_ways_lp-1:0]                  way_i,
  input  logic [lg_sets_lp-1:0]                  set_i,
  input  logic                                   bank_grant_i,
  input  logic                                   fifo_ready_i,
  input  logic                                   fifo_v_i,
  input  logic [evict_fill_pkg::dma_width_c-1:0] fifo_data_i,
  output logic                                   bank_v_o,
  output logic                                   bank_w_o,
  output logic [lg_sets_lp+lg_bursts_lp-1:0]     bank_addr_o,
  output logic [evict_fill_pkg::dma_width_c-1:0] bank_data_o,
  output logic [ways_p-1:0][mask_width_lp-1:0]   bank_w_mask_o,
  output logic                                   fifo_push_o,
  output logic                                   fifo_yumi_o,
  output logic                                   done_o
);

  localparam logic [cnt_width_lp-1:0] evict_last_lp = cnt_width_lp'(bursts_p + 1);
  localparam logic [cnt_width_lp-1:0] refill_last_lp = cnt_width_lp'(bursts_p);

  logic [cnt_width_lp-1:0] count_r;
  logic is_evict;
  logic is_refill;
  logic evict_step;
  logic evict_read;
  logic refill_write;

  assign is_evict = (mode_i == evict_fill_pkg::mode_evict);
  assign is_refill = (mode_i == evict_fill_pkg::mode_refill);

  // an evict step reads burst k and pushes the data of burst k-1 read one step earlier
  // the bank output is expected to hold its read data until the next read, as an SRAM does
  assign evict_step = is_evict & bank_grant_i & fifo_ready_i & (count_r != evict_last_lp);
  assign evict_read = evict_step & (count_r < refill_last_lp);
  assign fifo_push_o = evict_step & (count_r != '0);

  // refill writes the FIFO head straight into the bank
  assign refill_write = is_refill & bank_grant_i & fifo_v_i & (count_r != refill_last_lp);
  assign fifo_yumi_o = refill_write;

  assign bank_v_o = evict_read | refill_write;
  assign bank_w_o = refill_write;
  assign bank_addr_o = {set_i, count_r[lg_bursts_lp-1:0]};
  assign bank_data_o = fifo_data_i;

  assign done_o = (is_evict & (count_r == evict_last_lp))
                | (is_refill & (count_r == refill_last_lp));

  // whole beat for the chosen way and nothing for the others
  always_comb begin
    for (int w = 0; w < ways_p; w++) begin
      bank_w_mask_o[w] = (way_i == lg_ways_lp'(w)) ? '1 : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || (mode_i == evict_fill_pkg::mode_idle)) begin
      count_r <= '0;
    end else if (evict_step || refill_write) begin
      count_r <= count_r + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== design/evict_serializer.sv ====
`default_nettype none

module evict_serializer (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   v_i,
  input  logic [evict_fill_pkg::dma_width_c-1:0] even_data_i,
  input  logic [evict_fill_pkg::dma_width_c-1:0] odd_data_i,
  output logic                                   ready_o,
  output logic                                   v_o,
  output logic [evict_fill_pkg::dma_width_c-1:0] data_o,
  input  logic                                   yumi_i,
  output logic                                   empty_o
);

  logic [evict_fill_pkg::dma_width_c-1:0] even_r;
  logic [evict_fill_pkg::dma_width_c-1:0] odd_r;
  // number of beats of the held pair still to be sent
  logic [1:0] left_r;
  logic load;

  // a new pair may enter as the last held beat leaves
  assign ready_o = (left_r == 2'd0) | ((left_r == 2'd1) & yumi_i);
  assign load = v_i & ready_o;

  assign v_o = (left_r != 2'd0);
  assign data_o = (left_r == 2'd2) ? even_r : odd_r;
  assign empty_o = (left_r == 2'd0);

  always_ff @(posedge clk_i) begin
    if (load) begin
      even_r <= even_data_i;
      odd_r <= odd_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      left_r <= 2'd0;
    end else if (load) begin
      left_r <= 2'd2;
    end else if (yumi_i) begin
      left_r <= left_r - 2'd1;
    end
  end

endmodule

`default_nettype wire

// ==== design/evict_fill_top.sv ====
`default_nettype none

module evict_fill_top #(
  parameter int ways_p = evict_fill_pkg::default_ways_c,
  parameter int sets_p = evict_fill_pkg::default_sets_c,
  parameter int bursts_p = evict_fill_pkg::bursts_per_bank_c,
  localparam int lg_ways_lp = (ways_p > 1) ? $clog2(ways_p) : 1,
  localparam int lg_sets_lp = (sets_p > 1) ? $clog2(sets_p) : 1,
  localparam int lg_bursts_lp = (bursts_p > 1) ? $clog2(bursts_p) : 1,
  localparam int addr_width_lp = lg_sets_lp + lg_bursts_lp,
  localparam int dma_width_lp = evict_fill_pkg::dma_width_c,
  localparam int mask_width_lp = evict_fill_pkg::mask_width_c
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  cmd_v_i,
  input  logic                                  cmd_evict_i,
  input  logic [lg_ways_lp-1:0]                 cmd_way_i,
  input  logic [lg_sets_lp-1:0]                 cmd_set_i,
  output logic                                  cmd_ready_o,
  output logic                                  even_bank_v_o,
  output logic                                  even_bank_w_o,
  output logic [addr_width_lp-1:0]              even_bank_addr_o,
  output logic [dma_width_lp-1:0]               even_bank_data_o,
  output logic [ways_p-1:0][mask_width_lp-1:0]  even_bank_w_mask_o,
  input  logic                                  even_bank_grant_i,
  input  logic [ways_p-1:0][dma_width_lp-1:0]   even_bank_data_i,
  output logic                                  odd_bank_v_o,
  output logic                                  odd_bank_w_o,
  output logic [addr_width_lp-1:0]              odd_bank_addr_o,
  output logic [dma_width_lp-1:0]               odd_bank_data_o,
  output logic [ways_p-1:0][mask_width_lp-1:0]  odd_bank_w_mask_o,
  input  logic                                  odd_bank_grant_i,
  input  logic [ways_p-1:0][dma_width_lp-1:0]   odd_bank_data_i,
  input  logic                                  dma_refill_v_i,
  input  logic [1:0][dma_width_lp-1:0]          dma_refill_data_i,
  output logic                                  dma_refill_ready_o,
  output logic                                  dma_evict_v_o,
  output logic [dma_width_lp-1:0]               dma_evict_data_o,
  input  logic                                  dma_evict_yumi_i,
  output logic                                  evict_done_o,
  output logic                                  refill_done_o,
  output logic                                  busy_o
);

  evict_fill_pkg::mode_e mode;
  logic [lg_ways_lp-1:0] way;
  logic [lg_sets_lp-1:0] set;
  logic evict_sel;
  logic refill_sel;
  logic even_done;
  logic odd_done;
  logic drain_empty;
  logic refill_take;
  logic refill_open;
  logic even_push;
  logic odd_push;
  logic even_port_yumi;
  logic odd_port_yumi;
  logic even_fifo_v_li;
  logic odd_fifo_v_li;
  logic [dma_width_lp-1:0] even_fifo_data_li;
  logic [dma_width_lp-1:0] odd_fifo_data_li;
  logic even_fifo_ready_lo;
  logic odd_fifo_ready_lo;
  logic even_fifo_v_lo;
  logic odd_fifo_v_lo;
  logic [dma_width_lp-1:0] even_fifo_data_lo;
  logic [dma_width_lp-1:0] odd_fifo_data_lo;
  logic even_fifo_yumi_li;
  logic odd_fifo_yumi_li;
  logic ser_v_li;
  logic ser_ready_lo;
  logic ser_empty_lo;
  logic ser_take;

  assign evict_sel = (mode == evict_fill_pkg::mode_evict);
  assign refill_sel = (mode == evict_fill_pkg::mode_refill);
  assign busy_o = (mode != evict_fill_pkg::mode_idle);

  // a DMA pair is taken only when both halves fit
  assign dma_refill_ready_o = refill_sel & even_fifo_ready_lo & odd_fifo_ready_lo & refill_open;
  assign refill_take = dma_refill_v_i & dma_refill_ready_o;

  // FIFO inputs come from the selected way on evict and from DMA on refill
  assign even_fifo_v_li = evict_sel ? even_push : refill_take;
  assign odd_fifo_v_li = evict_sel ? odd_push : refill_take;
  assign even_fifo_data_li = evict_sel ? even_bank_data_i[way] : dma_refill_data_i[0];
  assign odd_fifo_data_li = evict_sel ? odd_bank_data_i[way] : dma_refill_data_i[1];

  // both FIFO heads move together into the serializer on evict
  assign ser_v_li = evict_sel & even_fifo_v_lo & odd_fifo_v_lo;
  assign ser_take = ser_v_li & ser_ready_lo;
  assign even_fifo_yumi_li = evict_sel ? ser_take : even_port_yumi;
  assign odd_fifo_yumi_li = evict_sel ? ser_take : odd_port_yumi;

  assign drain_empty = ser_empty_lo & ~even_fifo_v_lo & ~odd_fifo_v_lo;

  transfer_control #(
    .ways_p(ways_p),
    .sets_p(sets_p),
    .bursts_p(bursts_p)
  ) control (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .cmd_v_i(cmd_v_i),
    .cmd_evict_i(cmd_evict_i),
    .cmd_way_i(cmd_way_i),
    .cmd_set_i(cmd_set_i),
    .cmd_ready_o(cmd_ready_o),
    .even_done_i(even_done),
    .odd_done_i(odd_done),
    .drain_empty_i(drain_empty),
    .refill_take_i(refill_take),
    .refill_open_o(refill_open),
    .mode_o(mode),
    .way_o(way),
    .set_o(set),
    .evict_done_o(evict_done_o),
    .refill_done_o(refill_done_o)
  );

  bank_port #(
    .ways_p(ways_p),
    .sets_p(sets_p),
    .bursts_p(bursts_p)
  ) even_port (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .mode_i(mode),
    .way_i(way),
    .set_i(set),
    .bank_grant_i(even_bank_grant_i),
    .fifo_ready_i(even_fifo_ready_lo),
    .fifo_v_i(even_fifo_v_lo),
    .fifo_data_i(even_fifo_data_lo),
    .bank_v_o(even_bank_v_o),
    .bank_w_o(even_bank_w_o),
    .bank_addr_o(even_bank_addr_o),
    .bank_data_o(even_bank_data_o),
    .bank_w_mask_o(even_bank_w_mask_o),
    .fifo_push_o(even_push),
    .fifo_yumi_o(even_port_yumi),
    .done_o(even_done)
  );

  bank_port #(
    .ways_p(ways_p),
    .sets_p(sets_p),
    .bursts_p(bursts_p)
  ) odd_port (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .mode_i(mode),
    .way_i(way),
    .set_i(set),
    .bank_grant_i(odd_bank_grant_i),
    .fifo_ready_i(odd_fifo_ready_lo),
    .fifo_v_i(odd_fifo_v_lo),
    .fifo_data_i(odd_fifo_data_lo),
    .bank_v_o(odd_bank_v_o),
    .bank_w_o(odd_bank_w_o),
    .bank_addr_o(odd_bank_addr_o),
    .bank_data_o(odd_bank_data_o),
    .bank_w_mask_o(odd_bank_w_mask_o),
    .fifo_push_o(odd_push),
    .fifo_yumi_o(odd_port_yumi),
    .done_o(odd_done)
  );

  beat_fifo #(
    .els_p(2)
  ) even_fifo (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .v_i(even_fifo_v_li),
    .data_i(even_fifo_data_li),
    .ready_o(even_fifo_ready_lo),
    .v_o(even_fifo_v_lo),
    .data_o(even_fifo_data_lo),
    .yumi_i(even_fifo_yumi_li)
  );

  beat_fifo #(
    .els_p(2)
  ) odd_fifo (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .v_i(odd_fifo_v_li),
    .data_i(odd_fifo_data_li),
    .ready_o(odd_fifo_ready_lo),
    .v_o(odd_fifo_v_lo),
    .data_o(odd_fifo_data_lo),
    .yumi_i(odd_fifo_yumi_li)
  );

  evict_serializer serializer (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .v_i(ser_v_li),
    .even_data_i(even_fifo_data_lo),
    .odd_data_i(odd_fifo_data_lo),
    .ready_o(ser_ready_lo),
    .v_o(dma_evict_v_o),
    .data_o(dma_evict_data_o),
    .yumi_i(dma_evict_yumi_i),
    .empty_o(ser_empty_lo)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
  parameter int half_period_p = 4,
  parameter int reset_cycles_p = 16
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #half_period_p;
      clk_o = ~clk_o;
    end
  end

  // reset drops just after a rising edge, like every other driven input
  initial begin
    reset_o = 1'b1;
    repeat (reset_cycles_p) @(posedge clk_o);
    #1;
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

// ==== testbench/tb_evict_fill.sv ====
`default_nettype none

module tb_evict_fill;

  localparam int ways_c = evict_fill_pkg::default_ways_c;
  localparam int sets_c = evict_fill_pkg::default_sets_c;
  localparam int bursts_c = evict_fill_pkg::bursts_per_bank_c;
  localparam int beat_w_c = evict_fill_pkg::dma_width_c;
  localparam int mask_w_c = evict_fill_pkg::mask_width_c;
  localparam int lg_ways_c = (ways_c > 1) ? $clog2(ways_c) : 1;
  localparam int lg_sets_c = (sets_c > 1) ? $clog2(sets_c) : 1;
  localparam int lg_bursts_c = (bursts_c > 1) ? $clog2(bursts_c) : 1;
  localparam int addr_w_c = lg_sets_c + lg_bursts_c;
  localparam int num_transfers_c = 24;
  localparam int transfer_cycles_c = 150;
  localparam int cycle_limit_c = num_transfers_c * transfer_cycles_c + 400;

  logic clk;
  logic reset;
  logic cmd_v;
  logic cmd_evict;
  logic [lg_ways_c-1:0] cmd_way;
  logic [lg_sets_c-1:0] cmd_set;
  logic cmd_ready;
  logic even_v;
  logic even_w;
  logic [addr_w_c-1:0] even_addr;
  logic [beat_w_c-1:0] even_wdata;
  logic [ways_c-1:0][mask_w_c-1:0] even_mask;
  logic even_grant;
  logic odd_v;
  logic odd_w;
  logic [addr_w_c-1:0] odd_addr;
  logic [beat_w_c-1:0] odd_wdata;
  logic [ways_c-1:0][mask_w_c-1:0] odd_mask;
  logic odd_grant;
  logic [ways_c-1:0][beat_w_c-1:0] bank_rdata [2];
  logic dma_refill_v;
  logic [1:0][beat_w_c-1:0] dma_refill_data;
  logic dma_refill_ready;
  logic dma_evict_v;
  logic [beat_w_c-1:0] dma_evict_data;
  logic dma_evict_yumi;
  logic evict_done;
  logic refill_done;
  logic busy;

  // bank contents as the model holds them and as the DUT should leave them
  logic [beat_w_c-1:0] mem [2][ways_c][sets_c][bursts_c];
  logic [beat_w_c-1:0] ref_mem [2][ways_c][sets_c][bursts_c];
  logic [1:0][beat_w_c-1:0] exp_pair [bursts_c];
  logic [beat_w_c-1:0] evict_exp_q [$];
  logic [2*beat_w_c-1:0] refill_q [$];
  logic read_pending [2];
  logic [addr_w_c-1:0] read_addr [2];
  int rd_idx [2];
  int wr_idx [2];
  int pairs_taken;
  int cur_way;
  int cur_set;
  logic cur_evict;
  logic stall_yumi;
  logic stall_grant;
  logic stall_refill;
  logic refill_took;
  logic idle_check;
  logic evict_done_q;
  logic refill_done_q;
  logic [15:0] lfsr_r;
  int err_count;
  int beat_count;
  int evict_done_count;
  int refill_done_count;
  int transfer_count;
  int cycle_count;

  tb_clock_gen clock0 (
    .clk_o(clk),
    .reset_o(reset)
  );

  evict_fill_top dut0 (
    .clk_i(clk),
    .reset_i(reset),
    .cmd_v_i(cmd_v),
    .cmd_evict_i(cmd_evict),
    .cmd_way_i(cmd_way),
    .cmd_set_i(cmd_set),
    .cmd_ready_o(cmd_ready),
    .even_bank_v_o(even_v),
    .even_bank_w_o(even_w),
    .even_bank_addr_o(even_addr),
    .even_bank_data_o(even_wdata),
    .even_bank_w_mask_o(even_mask),
    .even_bank_grant_i(even_grant),
    .even_bank_data_i(bank_rdata[0]),
    .odd_bank_v_o(odd_v),
    .odd_bank_w_o(odd_w),
    .odd_bank_addr_o(odd_addr),
    .odd_bank_data_o(odd_wdata),
    .odd_bank_w_mask_o(odd_mask),
    .odd_bank_grant_i(odd_grant),
    .odd_bank_data_i(bank_rdata[1]),
    .dma_refill_v_i(dma_refill_v),
    .dma_refill_data_i(dma_refill_data),
    .dma_refill_ready_o(dma_refill_ready),
    .dma_evict_v_o(dma_evict_v),
    .dma_evict_data_o(dma_evict_data),
    .dma_evict_yumi_i(dma_evict_yumi),
    .evict_done_o(evict_done),
    .refill_done_o(refill_done),
    .busy_o(busy)
  );

  // fibonacci LFSR with the taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function logic draw_bit();
    lfsr_r = lfsr_step(lfsr_r);
    return lfsr_r[0];
  endfunction

  function logic [beat_w_c-1:0] draw_word();
    logic [beat_w_c-1:0] word;
    for (int i = 0; i < beat_w_c; i++) begin
      word[i] = draw_bit();
    end
    return word;
  endfunction

  function automatic logic [beat_w_c-1:0] fill_pattern(input int b, input int w, input int s,
                                                       input int k);
    return {16'hc0de, 8'(b), 8'(w), 8'(s), 8'(k), 16'h5a5a};
  endfunction

  function automatic logic [ways_c*mask_w_c-1:0] expected_mask(input int way);
    logic [ways_c*mask_w_c-1:0] m;
    m = '0;
    m[way*mask_w_c +: mask_w_c] = '1;
    return m;
  endfunction

  function automatic logic [addr_w_c-1:0] burst_addr(input int row, input int k);
    return addr_w_c'((row << lg_bursts_c) + k);
  endfunction

  task automatic report_error(input string msg);
    $display("ERR %0t: %s", $time, msg);
    err_count++;
  endtask

  // checks one bank request and plays it into the memory model
  task automatic check_bank(input int b, input logic v, input logic w, input logic grant,
                            input logic [addr_w_c-1:0] addr, input logic [beat_w_c-1:0] data,
                            input logic [ways_c*mask_w_c-1:0] mask);
    int row;
    int burst;
    row = int'(addr >> lg_bursts_c);
    burst = int'(addr[lg_bursts_c-1:0]);
    assert (!(v && !grant)) else report_error($sformatf("bank %0d request without grant", b));
    if (v && grant && w) begin
      assert (!cur_evict && wr_idx[b] < bursts_c)
      else report_error($sformatf("bank %0d unexpected write", b));
      if (wr_idx[b] < bursts_c) begin
        assert (addr == burst_addr(cur_set, wr_idx[b]))
        else report_error($sformatf("bank %0d write addr %h", b, addr));
        assert (data == exp_pair[wr_idx[b]][b])
        else report_error($sformatf("bank %0d write data %h, expected %h", b, data,
                                    exp_pair[wr_idx[b]][b]));
      end
      assert (mask == expected_mask(cur_way))
      else report_error($sformatf("bank %0d write mask %h for way %0d", b, mask, cur_way));
      for (int wy = 0; wy < ways_c; wy++) begin
        for (int by = 0; by < mask_w_c; by++) begin
          if (mask[wy*mask_w_c + by]) begin
            mem[b][wy][row][burst][by*8 +: 8] = data[by*8 +: 8];
          end
        end
      end
      wr_idx[b]++;
    end
    if (v && grant && !w) begin
      assert (cur_evict && rd_idx[b] < bursts_c && addr == burst_addr(cur_set, rd_idx[b]))
      else report_error($sformatf("bank %0d read addr %h, read %0d", b, addr, rd_idx[b]));
      rd_idx[b]++;
      read_pending[b] = 1'b1;
      read_addr[b] = addr;
    end
  endtask

  task automatic compare_memory();
    for (int b = 0; b < 2; b++) begin
      for (int w = 0; w < ways_c; w++) begin
        for (int s = 0; s < sets_c; s++) begin
          for (int k = 0; k < bursts_c; k++) begin
            assert (mem[b][w][s][k] == ref_mem[b][w][s][k])
            else report_error($sformatf("bank %0d way %0d set %0d burst %0d holds %h, expected %h",
                                        b, w, s, k, mem[b][w][s][k], ref_mem[b][w][s][k]));
          end
        end
      end
    end
  endtask

  // outputs are sampled at the falling edge half a cycle after the inputs settle
  always @(negedge clk) begin
    if (idle_check) begin
      assert (cmd_ready && !even_v && !odd_v && !dma_evict_v && !dma_refill_ready && !busy
              && !evict_done && !refill_done)
      else report_error("outputs not idle after reset");
    end
    if (!reset) begin
      check_bank(0, even_v, even_w, even_grant, even_addr, even_wdata, even_mask);
      check_bank(1, odd_v, odd_w, odd_grant, odd_addr, odd_wdata, odd_mask);
      if (dma_evict_v && dma_evict_yumi) begin
        assert (evict_exp_q.size() != 0)
        else report_error($sformatf("extra evict beat %h", dma_evict_data));
        if (evict_exp_q.size() != 0) begin
          assert (dma_evict_data == evict_exp_q[0])
          else report_error($sformatf("evict beat %h, expected %h", dma_evict_data,
                                      evict_exp_q[0]));
          void'(evict_exp_q.pop_front());
        end
        beat_count++;
      end
      // a refill takes one block of pairs and no more
      assert (!(dma_refill_ready && (cur_evict || pairs_taken >= bursts_c)))
      else report_error($sformatf("refill ready after %0d pairs", pairs_taken));
      refill_took = dma_refill_v && dma_refill_ready;
      if (refill_took) begin
        pairs_taken++;
      end
      assert (!(evict_done && refill_done)) else report_error("both done pulses high");
      assert (!(evict_done && evict_done_q) && !(refill_done && refill_done_q))
      else report_error("done held longer than one cycle");
      if (evict_done || refill_done) begin
        assert (busy && !cmd_ready)
        else report_error("busy low or command ready while a transfer finishes");
      end
      if (evict_done_q || refill_done_q) begin
        assert (!busy) else report_error("busy still high one cycle after done");
      end
      if (evict_done) begin
        evict_done_count++;
        assert (evict_exp_q.size() == 0)
        else report_error($sformatf("evict done with %0d beats missing", evict_exp_q.size()));
      end
      if (refill_done) begin
        refill_done_count++;
        assert (wr_idx[0] == bursts_c && wr_idx[1] == bursts_c)
        else report_error($sformatf("refill done after %0d/%0d writes", wr_idx[0], wr_idx[1]));
      end
      evict_done_q = evict_done;
      refill_done_q = refill_done;
    end
  end

  // bank read data, grants and DMA responses change just after the rising edge
  always @(posedge clk) begin
    #1;
    even_grant = stall_grant ? draw_bit() : 1'b1;
    odd_grant = stall_grant ? draw_bit() : 1'b1;
    dma_evict_yumi = dma_evict_v & (stall_yumi ? draw_bit() : 1'b1);
    for (int b = 0; b < 2; b++) begin
      if (read_pending[b]) begin
        for (int w = 0; w < ways_c; w++) begin
          bank_rdata[b][w] = mem[b][w][read_addr[b] >> lg_bursts_c][read_addr[b][lg_bursts_c-1:0]];
        end
        read_pending[b] = 1'b0;
      end
    end
    if (refill_took) begin
      void'(refill_q.pop_front());
    end
    if (refill_q.size() == 0) begin
      dma_refill_v = 1'b0;
    end else if (!dma_refill_v || refill_took) begin
      dma_refill_v = stall_refill ? draw_bit() : 1'b1;
      dma_refill_data = refill_q[0];
    end
  end

  task automatic run_transfer(input logic evict, input int way, input int row,
                              input logic yumi_stalls, input logic grant_stalls);
    int evict_start;
    int refill_start;
    logic [beat_w_c-1:0] even_beat;
    logic [beat_w_c-1:0] odd_beat;
    @(posedge clk);
    #2;
    stall_yumi = yumi_stalls;
    stall_grant = grant_stalls;
    stall_refill = grant_stalls;
    cur_way = way;
    cur_set = row;
    cur_evict = evict;
    pairs_taken = 0;
    for (int b = 0; b < 2; b++) begin
      rd_idx[b] = 0;
      wr_idx[b] = 0;
    end
    for (int k = 0; k < bursts_c; k++) begin
      if (evict) begin
        evict_exp_q.push_back(ref_mem[0][way][row][k]);
        evict_exp_q.push_back(ref_mem[1][way][row][k]);
      end else begin
        even_beat = draw_word();
        odd_beat = draw_word();
        exp_pair[k] = {odd_beat, even_beat};
        ref_mem[0][way][row][k] = even_beat;
        ref_mem[1][way][row][k] = odd_beat;
        refill_q.push_back({odd_beat, even_beat});
      end
    end
    @(posedge clk);
    #1;
    cmd_v = 1'b1;
    cmd_evict = evict;
    cmd_way = lg_ways_c'(way);
    cmd_set = lg_sets_c'(row);
    evict_start = evict_done_count;
    refill_start = refill_done_count;
    @(negedge clk);
    assert (cmd_ready) else report_error("command not accepted while idle");
    @(posedge clk);
    #1;
    cmd_v = 1'b0;
    while (evict_done_count == evict_start && refill_done_count == refill_start) begin
      @(posedge clk);
    end
    repeat (3) @(posedge clk);
    assert (evict_done_count == evict_start + int'(evict)
            && refill_done_count == refill_start + int'(!evict))
    else report_error("wrong number of done pulses");
    assert (evict_exp_q.size() == 0) else report_error("evict beats left over");
    compare_memory();
    transfer_count++;
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < cycle_limit_c) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the tests did not finish within %0d cycles", cycle_limit_c);
    $display("Verification failed");
    $finish;
  end

  initial begin
    logic evict;
    logic paired;
    int way;
    int row;
    lfsr_r = 16'd56;
    cmd_v = 1'b0;
    cmd_evict = 1'b0;
    cmd_way = '0;
    cmd_set = '0;
    even_grant = 1'b0;
    odd_grant = 1'b0;
    bank_rdata[0] = '0;
    bank_rdata[1] = '0;
    dma_refill_v = 1'b0;
    dma_refill_data = '0;
    dma_evict_yumi = 1'b0;
    read_pending[0] = 1'b0;
    read_pending[1] = 1'b0;
    refill_took = 1'b0;
    pairs_taken = 0;
    stall_yumi = 1'b0;
    stall_grant = 1'b0;
    stall_refill = 1'b0;
    idle_check = 1'b0;
    evict_done_q = 1'b0;
    refill_done_q = 1'b0;
    cur_evict = 1'b0;
    err_count = 0;
    beat_count = 0;
    evict_done_count = 0;
    refill_done_count = 0;
    transfer_count = 0;
    for (int b = 0; b < 2; b++) begin
      for (int w = 0; w < ways_c; w++) begin
        for (int s = 0; s < sets_c; s++) begin
          for (int k = 0; k < bursts_c; k++) begin
            mem[b][w][s][k] = fill_pattern(b, w, s, k);
            ref_mem[b][w][s][k] = fill_pattern(b, w, s, k);
          end
        end
      end
    end
    @(negedge reset);
    idle_check = 1'b1;
    repeat (3) @(posedge clk);
    idle_check = 1'b0;
    // plain evicts, then refill and evict pairs, then DMA and bank stalls
    for (int t = 0; t < num_transfers_c; t++) begin
      paired = (t >= 4 && t < 8) || (t >= 12);
      if (paired) begin
        evict = ((t % 2) == 1);
        way = (t / 2) % ways_c;
        row = ((t / 2) * 7 + 1) % sets_c;
      end else begin
        evict = 1'b1;
        way = t % ways_c;
        row = (t * 5) % sets_c;
      end
      run_transfer(evict, way, row, t >= 8, t >= 12);
    end
    repeat (4) @(posedge clk);
    $display("errors %0d, transfers %0d, evict beats %0d", err_count, transfer_count,
             beat_count);
    if (err_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
design/evict_fill_pkg.sv
design/beat_fifo.sv
design/transfer_control.sv
design/bank_port.sv
design/evict_serializer.sv
design/evict_fill_top.sv
testbench/tb_clock_gen.sv
testbench/tb_evict_fill.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_evict_fill
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= Verification passed

.PHONY: sim clean

# the run passes only if the pass line shows up in the simulator output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
